/* design/radio_pkg.sv */
// Shared definitions for the radio control block.
// Setting-bus addresses, readback selects, field widths and the
// vector and struct types passed between the control modules.

package radio_pkg;

   // Field widths
   localparam int CMD_W    = 64;
   localparam int ADDR_W   = 8;
   localparam int DATA_W   = 32;
   localparam int TIME_W   = 64;
   localparam int RB_SEL_W = 3;
   localparam int SAMPLE_W = 32;
   localparam int ATR_W    = 32;

   typedef logic [ADDR_W-1:0]   set_addr_t;
   typedef logic [DATA_W-1:0]   set_data_t;
   typedef logic [TIME_W-1:0]   vita_time_t;
   typedef logic [RB_SEL_W-1:0] rb_sel_t;
   typedef logic [SAMPLE_W-1:0] sample_t;
   typedef logic [ATR_W-1:0]    atr_t;

   // Command word as it arrives from the host
   typedef struct packed {
      logic                            wr;
      logic [CMD_W-ADDR_W-DATA_W-2:0]  rsvd;
      set_addr_t                       addr;
      set_data_t                       data;
   } cmd_word_t;

   typedef struct packed {
      logic      stb;
      set_addr_t addr;
      set_data_t data;
   } set_bus_t;

   // Run flags with bit 1 transmit and bit 0 receive
   typedef struct packed {
      logic tx;
      logic rx;
   } run_t;

   //////////////////////////////////////////////////////////////
   // Setting addresses
   localparam set_addr_t SR_ATR_BASE   = 8'd12;
   localparam int        SR_ATR_COUNT  = 4;
   localparam set_addr_t SR_TEST       = 8'd21;
   localparam set_addr_t SR_CODEC_IDLE = 8'd22;
   localparam set_addr_t SR_READBACK   = 8'd32;
   localparam set_addr_t SR_RUN        = 8'd33;
   localparam set_addr_t SR_TIME_BASE  = 8'd128;
   localparam set_addr_t SR_TIME_HI    = SR_TIME_BASE;
   localparam set_addr_t SR_TIME_LO    = SR_TIME_BASE + 8'd1;
   localparam set_addr_t SR_TIME_CTRL  = SR_TIME_BASE + 8'd2;

   //////////////////////////////////////////////////////////////
   // Readback selects
   localparam rb_sel_t RB_TEST     = 3'd0;
   localparam rb_sel_t RB_TIME     = 3'd1;
   localparam rb_sel_t RB_TIME_PPS = 3'd2;
   localparam rb_sel_t RB_CODEC    = 3'd3;
   localparam rb_sel_t RB_ATR      = 3'd4;

endpackage

/* design/ctrl_decoder.sv */
// Command decoder for the radio control block.
// Takes one command word at a time, puts writes on the setting bus
// and asks the responder for the readback word of every command.

`timescale 1ns/1ps

module ctrl_decoder (
   input  logic                 i_radio_clk,
   input  logic                 i_rst_n,
   input  radio_pkg::cmd_word_t i_ctrl_data,
   input  logic                 i_ctrl_valid,
   output logic                 o_ctrl_ready,
   input  logic                 i_resp_busy,
   output radio_pkg::set_bus_t  o_set,
   output logic                 o_rd_req
);

   typedef enum logic [1:0] {
      IDLE,
      ISSUE,
      WAIT
   } state_t;

   state_t               state_q;
   radio_pkg::cmd_word_t cmd_q;
   logic                 stb_q;
   logic                 rd_req_q;
   logic                 accept;

   assign o_ctrl_ready = (state_q == IDLE);
   assign accept       = i_ctrl_valid && o_ctrl_ready;

   always_ff @(posedge i_radio_clk) begin
      if (!i_rst_n) begin
         state_q  <= IDLE;
         stb_q    <= 1'b0;
         rd_req_q <= 1'b0;
      end else begin
         // Strobe and read request are single-cycle pulses
         stb_q    <= 1'b0;
         rd_req_q <= 1'b0;
         case (state_q)
            IDLE: begin
               if (accept) begin
                  state_q <= ISSUE;
               end
            end
            ISSUE: begin
               stb_q    <= cmd_q.wr;
               rd_req_q <= 1'b1;
               state_q  <= WAIT;
            end
            WAIT: begin
               // Hold off until the response has gone out
               if (!i_resp_busy) begin
                  state_q <= IDLE;
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   always_ff @(posedge i_radio_clk) begin
      if (accept) begin
         cmd_q <= i_ctrl_data;
      end
   end

   assign o_set.stb  = stb_q;
   assign o_set.addr = cmd_q.addr;
   assign o_set.data = cmd_q.data;
   assign o_rd_req   = rd_req_q;

endmodule

/* design/timekeeper.sv */
// Sample-time counter for the radio control block.
// Loads a 64-bit time now or at the next PPS rise, and keeps the
// time seen at the most recent PPS rise.

`timescale 1ns/1ps

module timekeeper (
   input  logic                  i_radio_clk,
   input  logic                  i_rst_n,
   input  radio_pkg::set_bus_t   i_set,
   input  logic                  i_pps,
   output radio_pkg::vita_time_t o_vita_time,
   output radio_pkg::vita_time_t o_vita_time_lastpps
);

   radio_pkg::set_data_t  pend_hi_q;
   radio_pkg::set_data_t  pend_lo_q;
   radio_pkg::vita_time_t time_q;
   radio_pkg::vita_time_t lastpps_q;
   logic                  armed_q;
   logic                  pps_q;
   logic                  pps_rise;
   logic                  ctrl_wr;
   logic                  load_now;
   logic                  load_pps;

   // Rise between the previous and current PPS samples
   assign pps_rise = i_pps && !pps_q;

   assign ctrl_wr  = i_set.stb && (i_set.addr == radio_pkg::SR_TIME_CTRL);
   assign load_now = ctrl_wr && i_set.data[0];
   assign load_pps = armed_q && pps_rise;

   always_ff @(posedge i_radio_clk) begin
      if (!i_rst_n) begin
         pend_hi_q <= '0;
         pend_lo_q <= '0;
         time_q    <= '0;
         lastpps_q <= '0;
         armed_q   <= 1'b0;
         pps_q     <= 1'b0;
      end else begin
         pps_q <= i_pps;
         if (i_set.stb && (i_set.addr == radio_pkg::SR_TIME_HI)) begin
            pend_hi_q <= i_set.data;
         end
         if (i_set.stb && (i_set.addr == radio_pkg::SR_TIME_LO)) begin
            pend_lo_q <= i_set.data;
         end
         // Control write with bit 0 clear waits for PPS
         if (ctrl_wr) begin
            armed_q <= !i_set.data[0];
         end else if (load_pps) begin
            armed_q <= 1'b0;
         end
         if (load_now || load_pps) begin
            time_q <= {pend_hi_q, pend_lo_q};
         end else begin
            time_q <= time_q + 64'd1;
         end
         if (pps_rise) begin
            lastpps_q <= time_q;
         end
      end
   end

   assign o_vita_time         = time_q;
   assign o_vita_time_lastpps = lastpps_q;

endmodule

/* design/radio_settings.sv */
// Settings registers of the radio control block.
// Holds the test, codec idle, readback select, run and ATR words,
// picks the transmit output and drives the front-end ATR pins.

`timescale 1ns/1ps

module radio_settings (
   input  logic                 i_radio_clk,
   input  logic                 i_rst_n,
   input  radio_pkg::set_bus_t  i_set,
   input  radio_pkg::sample_t   i_tx_sample,
   output radio_pkg::sample_t   o_tx,
   output radio_pkg::atr_t      o_fe_atr,
   output radio_pkg::rb_sel_t   o_rb_sel,
   output radio_pkg::set_data_t o_test
);

   radio_pkg::set_data_t test_q;
   radio_pkg::sample_t   idle_q;
   radio_pkg::rb_sel_t   rb_sel_q;
   radio_pkg::run_t      run_q;
   radio_pkg::atr_t      atr_q [radio_pkg::SR_ATR_COUNT];
   radio_pkg::atr_t      fe_atr_q;
   radio_pkg::set_addr_t atr_off;
   logic                 atr_hit;
   logic [1:0]           atr_sel;

   // ATR words sit at four consecutive addresses
   assign atr_off = i_set.addr - radio_pkg::SR_ATR_BASE;
   assign atr_hit = (atr_off < radio_pkg::set_addr_t'(radio_pkg::SR_ATR_COUNT));

   // Idle, rx only, tx only, full duplex
   assign atr_sel = {run_q.tx, run_q.rx};

   //////////////////////////////////////////////////////////////
   // Register writes

   always_ff @(posedge i_radio_clk) begin
      if (!i_rst_n) begin
         test_q   <= '0;
         idle_q   <= '0;
         rb_sel_q <= '0;
         run_q    <= '0;
         fe_atr_q <= '0;
         for (int i = 0; i < radio_pkg::SR_ATR_COUNT; i++) begin
            atr_q[i] <= '0;
         end
      end else begin
         if (i_set.stb) begin
            case (i_set.addr)
               radio_pkg::SR_TEST:       test_q   <= i_set.data;
               radio_pkg::SR_CODEC_IDLE: idle_q   <= i_set.data;
               radio_pkg::SR_READBACK:   rb_sel_q <= i_set.data[radio_pkg::RB_SEL_W-1:0];
               radio_pkg::SR_RUN:        run_q    <= radio_pkg::run_t'(i_set.data[1:0]);
               default: begin
                  if (atr_hit) begin
                     atr_q[atr_off[1:0]] <= i_set.data;
                  end
               end
            endcase
         end
         fe_atr_q <= atr_q[atr_sel];
      end
   end

   //////////////////////////////////////////////////////////////
   // Outputs

   // Idle word goes out whenever transmit is stopped
   assign o_tx     = run_q.tx ? i_tx_sample : idle_q;
   assign o_fe_atr = fe_atr_q;
   assign o_rb_sel = rb_sel_q;
   assign o_test   = test_q;

endmodule

/* design/readback_responder.sv */
// Readback responder for the radio control block.
// Latches the selected readback word on request and offers it on
// the response stream until the host takes it.

`timescale 1ns/1ps

module readback_responder (
   input  logic                         i_radio_clk,
   input  logic                         i_rst_n,
   input  logic                         i_rd_req,
   input  radio_pkg::rb_sel_t           i_rb_sel,
   input  radio_pkg::set_data_t         i_test,
   input  radio_pkg::vita_time_t        i_vita_time,
   input  radio_pkg::vita_time_t        i_vita_time_lastpps,
   input  radio_pkg::sample_t           i_rx,
   input  radio_pkg::sample_t           i_tx,
   input  radio_pkg::atr_t              i_fe_atr,
   output logic [radio_pkg::CMD_W-1:0]  o_resp_data,
   output logic                         o_resp_valid,
   input  logic                         i_resp_ready,
   output logic                         o_busy
);

   logic [radio_pkg::CMD_W-1:0] rb_mux;
   logic [radio_pkg::CMD_W-1:0] resp_q;
   logic                        valid_q;

   always_comb begin
      case (i_rb_sel)
         radio_pkg::RB_TEST:     rb_mux = {{(radio_pkg::CMD_W-radio_pkg::DATA_W){1'b0}}, i_test};
         radio_pkg::RB_TIME:     rb_mux = i_vita_time;
         radio_pkg::RB_TIME_PPS: rb_mux = i_vita_time_lastpps;
         radio_pkg::RB_CODEC:    rb_mux = {i_tx, i_rx};
         radio_pkg::RB_ATR:      rb_mux = {{(radio_pkg::CMD_W-radio_pkg::ATR_W){1'b0}}, i_fe_atr};
         default:                rb_mux = '0;
      endcase
   end

   always_ff @(posedge i_radio_clk) begin
      if (!i_rst_n) begin
         valid_q <= 1'b0;
      end else if (i_rd_req) begin
         valid_q <= 1'b1;
      end else if (valid_q && i_resp_ready) begin
         valid_q <= 1'b0;
      end
   end

   // Word is held as is while the host stalls
   always_ff @(posedge i_radio_clk) begin
      if (i_rd_req) begin
         resp_q <= rb_mux;
      end
   end

   assign o_resp_data  = resp_q;
   assign o_resp_valid = valid_q;
   // A pending request counts as busy too
   assign o_busy       = valid_q || i_rd_req;

endmodule

/* design/radio_ctrl_top.sv */
// Top level of the radio control and timekeeping block.
// Command words in, one response word out per command, plus the
// codec transmit word and the front-end ATR pins.

`timescale 1ns/1ps

module radio_ctrl_top (
   input  logic                        i_radio_clk,
   input  logic                        i_rst_n,
   input  radio_pkg::cmd_word_t        i_ctrl_data,
   input  logic                        i_ctrl_valid,
   output logic                        o_ctrl_ready,
   output logic [radio_pkg::CMD_W-1:0] o_resp_data,
   output logic                        o_resp_valid,
   input  logic                        i_resp_ready,
   input  logic                        i_pps,
   input  radio_pkg::sample_t          i_rx,
   input  radio_pkg::sample_t          i_tx_sample,
   output radio_pkg::sample_t          o_tx,
   output radio_pkg::atr_t             o_fe_atr
);

   radio_pkg::set_bus_t   set_bus;
   logic                  rd_req;
   logic                  resp_busy;
   radio_pkg::rb_sel_t    rb_sel;
   radio_pkg::set_data_t  test_val;
   radio_pkg::vita_time_t vita_time;
   radio_pkg::vita_time_t vita_time_lastpps;

   //////////////////////////////////////////////////////////////
   // Decode

   ctrl_decoder decoder_i (
      .i_radio_clk (i_radio_clk),
      .i_rst_n     (i_rst_n),
      .i_ctrl_data (i_ctrl_data),
      .i_ctrl_valid(i_ctrl_valid),
      .o_ctrl_ready(o_ctrl_ready),
      .i_resp_busy (resp_busy),
      .o_set       (set_bus),
      .o_rd_req    (rd_req)
   );

   //////////////////////////////////////////////////////////////
   // Execute

   timekeeper timekeeper_i (
      .i_radio_clk        (i_radio_clk),
      .i_rst_n            (i_rst_n),
      .i_set              (set_bus),
      .i_pps              (i_pps),
      .o_vita_time        (vita_time),
      .o_vita_time_lastpps(vita_time_lastpps)
   );

   radio_settings settings_i (
      .i_radio_clk(i_radio_clk),
      .i_rst_n    (i_rst_n),
      .i_set      (set_bus),
      .i_tx_sample(i_tx_sample),
      .o_tx       (o_tx),
      .o_fe_atr   (o_fe_atr),
      .o_rb_sel   (rb_sel),
      .o_test     (test_val)
   );

   //////////////////////////////////////////////////////////////
   // Result

   readback_responder responder_i (
      .i_radio_clk        (i_radio_clk),
      .i_rst_n            (i_rst_n),
      .i_rd_req           (rd_req),
      .i_rb_sel           (rb_sel),
      .i_test             (test_val),
      .i_vita_time        (vita_time),
      .i_vita_time_lastpps(vita_time_lastpps),
      .i_rx               (i_rx),
      .i_tx               (o_tx),
      .i_fe_atr           (o_fe_atr),
      .o_resp_data        (o_resp_data),
      .o_resp_valid       (o_resp_valid),
      .i_resp_ready       (i_resp_ready),
      .o_busy             (resp_busy)
   );

endmodule

/* verification/radio_ctrl_chk.sv */
// Handshake and reset assertions for the radio control block.
// Bound into the top level and watches its stream ports.

`timescale 1ns/1ps

module radio_ctrl_chk (
   input logic                        i_radio_clk,
   input logic                        i_rst_n,
   input logic                        o_ctrl_ready,
   input logic [radio_pkg::CMD_W-1:0] o_resp_data,
   input logic                        o_resp_valid,
   input logic                        i_resp_ready
);

   int fail_count = 0;

   // A stalled response keeps valid and its word
   resp_hold: assert property (@(posedge i_radio_clk) disable iff (!i_rst_n)
      o_resp_valid && !i_resp_ready |=> o_resp_valid && $stable(o_resp_data))
   else begin
      $error("Response valid dropped or data changed before the transfer");
      fail_count++;
   end

   // No new command while a response is held
   ready_low: assert property (@(posedge i_radio_clk) disable iff (!i_rst_n)
      o_resp_valid |-> !o_ctrl_ready)
   else begin
      $error("Command ready high while a response is held");
      fail_count++;
   end

   reset_state: assert property (@(posedge i_radio_clk)
      !i_rst_n |=> !o_resp_valid && o_ctrl_ready)
   else begin
      $error("Stream handshake not idle after reset");
      fail_count++;
   end

endmodule

bind radio_ctrl_top radio_ctrl_chk chk_i (
   .i_radio_clk (i_radio_clk),
   .i_rst_n     (i_rst_n),
   .o_ctrl_ready(o_ctrl_ready),
   .o_resp_data (o_resp_data),
   .o_resp_valid(o_resp_valid),
   .i_resp_ready(i_resp_ready)
);

/* verification/radio_ctrl_monitor.sv */
// Reference model and scoreboard for the radio control testbench.
// Mirrors the settings registers and the sample-time counter, checks
// each response at its transfer edge and the output pins every cycle.

`timescale 1ns/1ps

module radio_ctrl_monitor (
   input  logic                        i_clk,
   input  logic                        i_rst_n,
   input  radio_pkg::cmd_word_t        i_ctrl_data,
   input  logic                        i_ctrl_valid,
   input  logic                        i_ctrl_ready,
   input  logic [radio_pkg::CMD_W-1:0] i_resp_data,
   input  logic                        i_resp_valid,
   input  logic                        i_resp_ready,
   input  logic                        i_pps,
   input  radio_pkg::sample_t          i_rx,
   input  radio_pkg::sample_t          i_tx_sample,
   input  radio_pkg::sample_t          i_tx,
   input  radio_pkg::atr_t             i_fe_atr,
   input  int                          i_test_id,
   input  logic                        i_test_end,
   output int                          o_errors,
   output int                          o_commands,
   output int                          o_responses
);

   radio_pkg::set_data_t        m_test;
   radio_pkg::sample_t          m_idle;
   radio_pkg::rb_sel_t          m_rb_sel;
   radio_pkg::run_t             m_run;
   radio_pkg::atr_t             m_atr [4];
   radio_pkg::atr_t             m_fe_atr;
   radio_pkg::vita_time_t       m_time;
   radio_pkg::vita_time_t       m_lastpps;
   radio_pkg::set_data_t        m_pend_hi;
   radio_pkg::set_data_t        m_pend_lo;
   logic                        m_armed;
   logic                        m_pps_q;
   // Command in flight and its age in cycles
   radio_pkg::cmd_word_t        p_cmd;
   int                          p_stage;
   logic [radio_pkg::CMD_W-1:0] exp_q [$];
   int                          err_base;
   int                          resp_base;

   function automatic string test_name(input int id);
      case (id)
         0:       return "test register";
         1:       return "time load";
         2:       return "PPS load and latch";
         3:       return "codec output";
         4:       return "ATR output";
         default: return "random stalls";
      endcase
   endfunction

   // Response word from the mirrored state before the capture edge
   function automatic logic [radio_pkg::CMD_W-1:0] model_readback(
      input radio_pkg::sample_t tx,
      input radio_pkg::sample_t rx
   );
      case (m_rb_sel)
         radio_pkg::RB_TEST:     return {32'd0, m_test};
         radio_pkg::RB_TIME:     return m_time;
         radio_pkg::RB_TIME_PPS: return m_lastpps;
         radio_pkg::RB_CODEC:    return {tx, rx};
         radio_pkg::RB_ATR:      return {32'd0, m_fe_atr};
         default:                return '0;
      endcase
   endfunction

   task automatic report_mismatch(input string what, input logic [63:0] exp,
                                  input logic [63:0] got);
      $display("MISMATCH at %0t: %s expected %h, got %h", $time, what, exp, got);
      o_errors++;
   endtask

   always @(posedge i_clk) begin
      radio_pkg::sample_t    exp_tx;
      radio_pkg::cmd_word_t  w_cmd;
      radio_pkg::vita_time_t next_time;
      radio_pkg::atr_t       next_fe;
      logic [7:0]            atr_off;
      logic                  wr_now;
      logic                  ctrl_wr;
      logic                  rise;
      logic                  load_pps;
      if (!i_rst_n) begin
         m_test      = '0;
         m_idle      = '0;
         m_rb_sel    = '0;
         m_run       = '0;
         m_fe_atr    = '0;
         m_time      = '0;
         m_lastpps   = '0;
         m_pend_hi   = '0;
         m_pend_lo   = '0;
         m_armed     = 1'b0;
         m_pps_q     = 1'b0;
         p_stage     = 0;
         o_errors    = 0;
         o_commands  = 0;
         o_responses = 0;
         err_base    = 0;
         resp_base   = 0;
         exp_q.delete();
         for (int i = 0; i < 4; i++) begin
            m_atr[i] = '0;
         end
      end else begin
         // Pins as they stand before this edge
         exp_tx = m_run.tx ? i_tx_sample : m_idle;
         if (i_tx !== exp_tx) begin
            report_mismatch("o_tx", {32'd0, exp_tx}, {32'd0, i_tx});
         end
         if (i_fe_atr !== m_fe_atr) begin
            report_mismatch("o_fe_atr", {32'd0, m_fe_atr}, {32'd0, i_fe_atr});
         end
         if (i_resp_valid && i_resp_ready) begin
            if (exp_q.size() == 0) begin
               $display("Unexpected response at %0t with no command outstanding", $time);
               o_errors++;
            end else begin
               o_responses++;
               report_if_wrong: begin
                  logic [63:0] exp_resp;
                  exp_resp = exp_q.pop_front();
                  if (i_resp_data !== exp_resp) begin
                     report_mismatch("response", exp_resp, i_resp_data);
                  end
               end
            end
         end
         // Capture and write both land two edges after the accept
         wr_now = 1'b0;
         w_cmd  = p_cmd;
         if (p_stage == 2) begin
            exp_q.push_back(model_readback(exp_tx, i_rx));
            wr_now  = w_cmd.wr;
            p_stage = 0;
         end else if (p_stage == 1) begin
            p_stage = 2;
         end
         if (i_ctrl_valid && i_ctrl_ready) begin
            p_cmd   = i_ctrl_data;
            p_stage = 1;
            o_commands++;
         end
         ctrl_wr   = wr_now && (w_cmd.addr == radio_pkg::SR_TIME_CTRL);
         rise      = i_pps && !m_pps_q;
         load_pps  = m_armed && rise;
         next_time = ((ctrl_wr && w_cmd.data[0]) || load_pps) ? {m_pend_hi, m_pend_lo}
                                                              : m_time + 64'd1;
         next_fe   = m_atr[{m_run.tx, m_run.rx}];
         if (rise) begin
            m_lastpps = m_time;
         end
         if (ctrl_wr) begin
            m_armed = !w_cmd.data[0];
         end else if (load_pps) begin
            m_armed = 1'b0;
         end
         m_time   = next_time;
         m_fe_atr = next_fe;
         m_pps_q  = i_pps;
         if (wr_now) begin
            atr_off = w_cmd.addr - radio_pkg::SR_ATR_BASE;
            case (w_cmd.addr)
               radio_pkg::SR_TEST:       m_test    = w_cmd.data;
               radio_pkg::SR_CODEC_IDLE: m_idle    = w_cmd.data;
               radio_pkg::SR_READBACK:   m_rb_sel  = w_cmd.data[2:0];
               radio_pkg::SR_RUN:        m_run     = radio_pkg::run_t'(w_cmd.data[1:0]);
               radio_pkg::SR_TIME_HI:    m_pend_hi = w_cmd.data;
               radio_pkg::SR_TIME_LO:    m_pend_lo = w_cmd.data;
               default: begin
                  if (atr_off < 8'd4) begin
                     m_atr[atr_off[1:0]] = w_cmd.data;
                  end
               end
            endcase
         end
         if (i_test_end) begin
            if (exp_q.size() != 0 || p_stage != 0 || o_commands != o_responses) begin
               $display("Missing response: %0d commands accepted but %0d responses returned",
                        o_commands, o_responses);
               o_errors++;
            end
            $display("Test %0d (%s) done: %0d responses, %0d errors", i_test_id,
                     test_name(i_test_id), o_responses - resp_base, o_errors - err_base);
            resp_base = o_responses;
            err_base  = o_errors;
         end
      end
   end

endmodule

/* verification/tb_radio_ctrl.sv */
// Testbench for the radio control block.
// Sends seeded random commands over the command stream, stalls the
// response stream at random and drives random codec and PPS pins.

`timescale 1ns/1ps

module tb_radio_ctrl;

   localparam int CLK_PERIOD = 20;
   localparam int RST_CYCLES = 10;
   localparam int N_TESTS    = 6;
   localparam int N_CMDS     = 80;
   // Worst case cycles for one command with stalls
   localparam int CMD_CYCLES = 40;
   localparam int WATCHDOG   = (N_TESTS * N_CMDS * CMD_CYCLES + RST_CYCLES + 500) * CLK_PERIOD;

   logic                        clk = 1'b0;
   logic                        rst_n;
   radio_pkg::cmd_word_t        ctrl_data;
   logic                        ctrl_valid;
   logic                        ctrl_ready;
   logic [radio_pkg::CMD_W-1:0] resp_data;
   logic                        resp_valid;
   logic                        resp_ready;
   logic                        pps;
   radio_pkg::sample_t          rx;
   radio_pkg::sample_t          tx_sample;
   radio_pkg::sample_t          tx;
   radio_pkg::atr_t             fe_atr;
   int                          test_id;
   logic                        test_end;
   int                          errors;
   int                          commands;
   int                          responses;
   int                          assert_fails;
   integer                      seed = 32'h9936fe17;

   always #(CLK_PERIOD / 2) clk = ~clk;

   radio_ctrl_top dut_i (
      .i_radio_clk (clk),
      .i_rst_n     (rst_n),
      .i_ctrl_data (ctrl_data),
      .i_ctrl_valid(ctrl_valid),
      .o_ctrl_ready(ctrl_ready),
      .o_resp_data (resp_data),
      .o_resp_valid(resp_valid),
      .i_resp_ready(resp_ready),
      .i_pps       (pps),
      .i_rx        (rx),
      .i_tx_sample (tx_sample),
      .o_tx        (tx),
      .o_fe_atr    (fe_atr)
   );

   radio_ctrl_monitor mon_i (
      .i_clk       (clk),
      .i_rst_n     (rst_n),
      .i_ctrl_data (ctrl_data),
      .i_ctrl_valid(ctrl_valid),
      .i_ctrl_ready(ctrl_ready),
      .i_resp_data (resp_data),
      .i_resp_valid(resp_valid),
      .i_resp_ready(resp_ready),
      .i_pps       (pps),
      .i_rx        (rx),
      .i_tx_sample (tx_sample),
      .i_tx        (tx),
      .i_fe_atr    (fe_atr),
      .i_test_id   (test_id),
      .i_test_end  (test_end),
      .o_errors    (errors),
      .o_commands  (commands),
      .o_responses (responses)
   );

   //////////////////////////////////////////////////////////////
   // Stimulus helpers

   // Advance one cycle, then drive fresh pin values and response stalls
   task automatic next_cycle();
      logic [31:0] rnd;
      @(posedge clk);
      #1;
      rnd        = $random(seed);
      rx         = $random(seed);
      tx_sample  = $random(seed);
      // Dense PPS pulses in the PPS test
      pps        = (test_id == 2) ? (rnd[2:0] == 3'd0) : (rnd[5:0] == 6'd0);
      resp_ready = (test_id == 5) ? (rnd[9:8] == 2'd0) : (rnd[9:8] != 2'd0);
   endtask

   function automatic radio_pkg::set_addr_t pick_addr(input int sel, input logic [3:0] r);
      case (sel)
         0: return r[0] ? radio_pkg::SR_TEST : radio_pkg::SR_READBACK;
         1, 2: begin
            case (r[1:0])
               2'd0:    return radio_pkg::SR_TIME_HI;
               2'd1:    return radio_pkg::SR_TIME_LO;
               2'd2:    return radio_pkg::SR_TIME_CTRL;
               default: return radio_pkg::SR_READBACK;
            endcase
         end
         3: begin
            case (r[1:0])
               2'd0:    return radio_pkg::SR_CODEC_IDLE;
               2'd1:    return radio_pkg::SR_RUN;
               default: return radio_pkg::SR_READBACK;
            endcase
         end
         default: begin
            if (!r[3]) begin
               return radio_pkg::SR_ATR_BASE + {6'd0, r[1:0]};
            end
            return r[2] ? radio_pkg::SR_RUN : radio_pkg::SR_READBACK;
         end
      endcase
   endfunction

   function automatic radio_pkg::rb_sel_t favored_sel(input int sel);
      case (sel)
         0:       return radio_pkg::RB_TEST;
         1:       return radio_pkg::RB_TIME;
         2:       return radio_pkg::RB_TIME_PPS;
         3:       return radio_pkg::RB_CODEC;
         default: return radio_pkg::RB_ATR;
      endcase
   endfunction

   //////////////////////////////////////////////////////////////
   // Main sequence

   initial begin
      radio_pkg::cmd_word_t cmd;
      logic [31:0]          r1;
      logic [31:0]          r2;
      int                   sel;
      logic                 taken;
      rst_n      = 1'b0;
      ctrl_valid = 1'b0;
      ctrl_data  = '0;
      resp_ready = 1'b0;
      pps        = 1'b0;
      rx         = '0;
      tx_sample  = '0;
      test_id    = 0;
      test_end   = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      #1;
      rst_n = 1'b1;
      for (int t = 0; t < N_TESTS; t++) begin
         test_id = t;
         for (int c = 0; c < N_CMDS; c++) begin
            r1 = $random(seed);
            r2 = $random(seed);
            // Last test mixes all the others under heavy stalls
            sel      = (t == 5) ? int'(r1[14:12]) % 5 : t;
            cmd.wr   = (r1[1:0] != 2'd0);
            cmd.rsvd = r2[22:0];
            cmd.addr = pick_addr(sel, r1[7:4]);
            cmd.data = $random(seed);
            if (cmd.addr == radio_pkg::SR_READBACK && r2[24:23] != 2'd0) begin
               cmd.data[radio_pkg::RB_SEL_W-1:0] = favored_sel(sel);
            end
            repeat (int'(r1[9:8])) next_cycle();
            ctrl_valid = 1'b1;
            ctrl_data  = cmd;
            taken      = 1'b0;
            while (!taken) begin
               taken = ctrl_ready;
               next_cycle();
            end
            ctrl_valid = 1'b0;
            taken      = 1'b0;
            while (!taken) begin
               taken = resp_valid && resp_ready;
               next_cycle();
            end
         end
         test_end = 1'b1;
         next_cycle();
         test_end = 1'b0;
      end
      repeat (4) next_cycle();
      assert_fails = dut_i.chk_i.fail_count;
      $display("Summary: %0d commands, %0d responses, %0d errors, %0d assertion failures",
               commands, responses, errors, assert_fails);
      if (errors == 0 && assert_fails == 0 && commands == N_TESTS * N_CMDS &&
          responses == commands) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG);
      $display("Timeout: the command sequence did not finish in time");
      $display("TEST RESULT: FAIL");
      $finish;
   end

endmodule

/* radio_ctrl_top.f */
design/radio_pkg.sv
design/ctrl_decoder.sv
design/timekeeper.sv
design/radio_settings.sv
design/readback_responder.sv
design/radio_ctrl_top.sv
verification/radio_ctrl_chk.sv
verification/radio_ctrl_monitor.sv
verification/tb_radio_ctrl.sv

/* Makefile */
# Verilator build and run for the radio control block

VERILATOR ?= verilator
TOP       ?= tb_radio_ctrl
FILELIST  ?= radio_ctrl_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  := TEST RESULT: PASS

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) $(SIM_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
